// File: rtl/vtp_pkg.sv
// ======================================================================
// Widths, localparams and shared types of the VTP request channel
// Request, stage record and translation lookup structs
// ======================================================================
`default_nettype none

package vtp_pkg;

    // Address geometry for 4 KB pages of 64-byte lines
    localparam int LINE_ADDR_BITS   = 26;
    localparam int PAGE_OFFSET_BITS = 6;
    localparam int PAGE_IDX_BITS    = 20;

    // Direct-mapped L1 TLB, 64 entries
    localparam int TLB_IDX_BITS = 6;
    localparam int TLB_TAG_BITS = 14;

    // Requests in flight, sizes the heap and the reply FIFO
    localparam int N_REQ_TAGS = 16;
    localparam int TAG_BITS   = 4;
    localparam int META_BITS  = 16;

    typedef logic [LINE_ADDR_BITS-1:0]   t_line_addr;
    typedef logic [PAGE_OFFSET_BITS-1:0] t_page_offset;
    typedef logic [PAGE_IDX_BITS-1:0]    t_page_idx;
    typedef logic [TLB_IDX_BITS-1:0]     t_tlb_idx;
    typedef logic [TLB_TAG_BITS-1:0]     t_tlb_tag;
    typedef logic [TAG_BITS-1:0]         t_req_tag;
    typedef logic [META_BITS-1:0]        t_req_meta;

    // Inbound and outbound request
    typedef struct packed {
        t_req_meta  meta;
        t_line_addr line_addr;
        logic       is_virtual;
    } t_vtp_req;

    // One pipeline stage record
    typedef struct packed {
        logic         valid;
        t_page_idx    page;
        t_page_offset offset;
        logic         is_virtual;
        t_req_tag     tag;
    } t_vtp_stage;

    // Translation service lookup and reply
    typedef struct packed {
        t_page_idx page_va;
        t_req_tag  tag;
    } t_vtp_lookup_req;

    typedef struct packed {
        t_page_idx page_pa;
        t_req_tag  tag;
    } t_vtp_lookup_rsp;

    typedef enum logic {
        TLB_CLEARING,
        TLB_READY
    } t_tlb_clear_state;

endpackage

`default_nettype wire

// File: rtl/vtp_req_intake.sv
// ======================================================================
// Request intake: registered ready and stage records st0 to st3
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module vtp_req_intake
    import vtp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    input  wire logic       req_valid,
    input  wire t_vtp_req   req,
    output logic            req_ready,

    input  wire logic       out_almost_full,
    input  wire logic       svc_ready,
    input  wire logic       tlb_ready,
    input  wire logic       heap_not_full,
    input  wire logic       rsp_pending,
    input  wire t_req_tag   alloc_tag,

    output t_vtp_stage      st0,
    output t_vtp_stage      st1,
    output t_vtp_stage      st2,
    output t_vtp_stage      st3
);

    // Most of the readiness is registered for timing
    logic ready_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready_q <= 1'b0;
        end
        else
        begin
            // Pending replies hold off intake so a bubble opens for them
            ready_q <= svc_ready && tlb_ready && !rsp_pending && !out_almost_full;
        end
    end

    // Heap space is known in the current cycle
    assign req_ready = ready_q && heap_not_full;

    // ==================================================================
    // Stage 0, split the line address into page and offset
    // ==================================================================

    always_comb
    begin
        st0.valid      = req_valid && req_ready;
        st0.page       = req.line_addr[LINE_ADDR_BITS-1:PAGE_OFFSET_BITS];
        st0.offset     = req.line_addr[PAGE_OFFSET_BITS-1:0];
        st0.is_virtual = req.is_virtual;
        // Heap hands out the tag in the same cycle
        st0.tag        = alloc_tag;
    end

    // Stages 1 to 3 just shift the record along
    always_ff @(posedge clk)
    begin
        st1 <= st0;
        st2 <= st1;
        st3 <= st2;

        // Only the valid bits need clearing
        if (reset)
        begin
            st1.valid <= 1'b0;
            st2.valid <= 1'b0;
            st3.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vtp_req_heap.sv
// ======================================================================
// Request heap: tag free list plus per-tag metadata and line address
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module vtp_req_heap
    import vtp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    input  wire logic       alloc_en,
    output t_req_tag        alloc_tag,
    output logic            not_full,

    input  wire logic       wr_en,
    input  wire t_req_tag   wr_tag,
    input  wire t_req_meta  wr_meta,
    input  wire t_line_addr wr_page_va,

    input  wire t_req_tag   rd_tag,
    output t_req_meta       rd_meta,
    output t_line_addr      rd_page_va,

    input  wire logic       free_en,
    input  wire t_req_tag   free_tag
);

    // One bit per tag, set while the tag is free
    logic [N_REQ_TAGS-1:0] free_map;

    // Write command held one cycle, committed in stage 1
    logic       wr_en_q;
    t_req_tag   wr_tag_q;
    t_req_meta  wr_meta_q;
    t_line_addr wr_va_q;

    t_req_meta  meta_mem [N_REQ_TAGS];
    t_line_addr va_mem   [N_REQ_TAGS];

    // Lowest free tag wins
    always_comb
    begin
        alloc_tag = '0;
        for (int i = N_REQ_TAGS - 1; i >= 0; i--)
        begin
            if (free_map[i])
                alloc_tag = t_req_tag'(i);
        end
    end

    assign not_full = |free_map;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_map <= '1;
            wr_en_q  <= 1'b0;
        end
        else
        begin
            // An allocated tag is never the one being freed
            if (alloc_en)
                free_map[alloc_tag] <= 1'b0;
            if (free_en)
                free_map[free_tag] <= 1'b1;
            wr_en_q <= wr_en;
        end
    end

    // Storage and registered read
    always_ff @(posedge clk)
    begin
        wr_tag_q  <= wr_tag;
        wr_meta_q <= wr_meta;
        wr_va_q   <= wr_page_va;

        if (wr_en_q)
        begin
            meta_mem[wr_tag_q] <= wr_meta_q;
            va_mem[wr_tag_q]   <= wr_va_q;
        end

        rd_meta    <= meta_mem[rd_tag];
        rd_page_va <= va_mem[rd_tag];
    end

endmodule

`default_nettype wire

// File: rtl/vtp_l1_tlb.sv
// ======================================================================
// Direct-mapped 64-entry L1 TLB with clearing sweep and fill port
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module vtp_l1_tlb
    import vtp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    input  wire logic       inval,
    output logic            ready,

    input  wire t_vtp_stage st0,
    input  wire t_vtp_stage st2,
    output logic            hit,
    output t_page_idx       hit_pa,

    input  wire logic       fill_en,
    input  wire t_page_idx  fill_va,
    input  wire t_page_idx  fill_pa
);

    t_tlb_clear_state clear_state;
    t_tlb_idx         clear_idx;

    // Invalidate strobe, delayed two stages
    logic inval_q1;
    logic inval_q2;

    logic      valid_mem [1 << TLB_IDX_BITS];
    t_tlb_tag  tag_mem   [1 << TLB_IDX_BITS];
    t_page_idx pa_mem    [1 << TLB_IDX_BITS];

    // Read data pipeline, one register per stage
    logic      rd_valid_q;
    t_tlb_tag  rd_tag_q;
    t_page_idx rd_pa_q;
    logic      rd_valid_qq;
    t_tlb_tag  rd_tag_qq;
    t_page_idx rd_pa_qq;

    // ==================================================================
    // Clearing sweep
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inval_q1    <= 1'b0;
            inval_q2    <= 1'b0;
            clear_state <= TLB_CLEARING;
            clear_idx   <= '0;
        end
        else
        begin
            inval_q1 <= inval;
            inval_q2 <= inval_q1;
            if (inval_q2)
            begin
                // Restart the sweep from entry 0
                clear_state <= TLB_CLEARING;
                clear_idx   <= '0;
            end
            else if (clear_state == TLB_CLEARING)
            begin
                clear_idx <= clear_idx + 1'b1;
                if (clear_idx == '1)
                    clear_state <= TLB_READY;
            end
        end
    end

    assign ready = (clear_state == TLB_READY);

    // Sweep writes take priority over fills
    always_ff @(posedge clk)
    begin
        if (clear_state == TLB_CLEARING)
        begin
            valid_mem[clear_idx] <= 1'b0;
        end
        else if (fill_en)
        begin
            valid_mem[fill_va[TLB_IDX_BITS-1:0]] <= 1'b1;
            tag_mem[fill_va[TLB_IDX_BITS-1:0]]   <= fill_va[PAGE_IDX_BITS-1:TLB_IDX_BITS];
            pa_mem[fill_va[TLB_IDX_BITS-1:0]]    <= fill_pa;
        end
    end

    // ==================================================================
    // Lookup, read at st0 and compare at st2
    // ==================================================================

    always_ff @(posedge clk)
    begin
        rd_valid_q  <= valid_mem[st0.page[TLB_IDX_BITS-1:0]];
        rd_tag_q    <= tag_mem[st0.page[TLB_IDX_BITS-1:0]];
        rd_pa_q     <= pa_mem[st0.page[TLB_IDX_BITS-1:0]];
        rd_valid_qq <= rd_valid_q;
        rd_tag_qq   <= rd_tag_q;
        rd_pa_qq    <= rd_pa_q;
        hit_pa      <= rd_pa_qq;
    end

    // Hit lines up with st3
    always_ff @(posedge clk)
    begin
        if (reset)
            hit <= 1'b0;
        else
            hit <= rd_valid_qq && (rd_tag_qq == st2.page[PAGE_IDX_BITS-1:TLB_IDX_BITS]);
    end

endmodule

`default_nettype wire

// File: rtl/vtp_miss_path.sv
// ======================================================================
// Miss path: service lookups, reply FIFO and bubble injection
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module vtp_miss_path
    import vtp_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset,

    input  wire t_vtp_stage      st2,
    input  wire t_vtp_stage      st3,
    input  wire logic            hit,

    output logic                 svc_lookup_en,
    output t_vtp_lookup_req      svc_lookup,
    input  wire logic            svc_rsp_valid,
    input  wire t_vtp_lookup_rsp svc_rsp,

    output logic                 rsp_pending,
    output logic                 inject_q,
    output t_vtp_lookup_rsp      inject_rsp,
    output t_req_tag             heap_rd_tag
);

    // Lookup for a virtual st3 request that missed the L1 TLB
    always_ff @(posedge clk)
    begin
        if (reset)
            svc_lookup_en <= 1'b0;
        else
            svc_lookup_en <= st3.valid && st3.is_virtual && !hit;

        svc_lookup.page_va <= st3.page;
        svc_lookup.tag     <= st3.tag;
    end

    // ==================================================================
    // Reply FIFO, one slot per tag so it never overflows
    // ==================================================================

    t_vtp_lookup_rsp fifo_mem [N_REQ_TAGS];
    logic [TAG_BITS:0] wr_ptr;
    logic [TAG_BITS:0] rd_ptr;
    t_vtp_lookup_rsp   fifo_head;
    logic              deq;

    assign rsp_pending = (wr_ptr != rd_ptr);
    assign fifo_head   = fifo_mem[rd_ptr[TAG_BITS-1:0]];

    // A free st2 slot means st3 is empty next cycle
    assign deq = rsp_pending && !st2.valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            inject_q <= 1'b0;
        end
        else
        begin
            if (svc_rsp_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq)
                rd_ptr <= rd_ptr + 1'b1;
            inject_q <= deq;
        end
    end

    always_ff @(posedge clk)
    begin
        if (svc_rsp_valid)
            fifo_mem[wr_ptr[TAG_BITS-1:0]] <= svc_rsp;

        inject_rsp <= fifo_head;

        // Heap read follows whichever request reaches the emitter next
        heap_rd_tag <= deq ? fifo_head.tag : st2.tag;
    end

endmodule

`default_nettype wire

// File: rtl/vtp_phys_emit.sv
// ======================================================================
// Emitter: picks hit or reply path, forms the physical request, fills TLB
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module vtp_phys_emit
    import vtp_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset,

    input  wire t_vtp_stage      st3,
    input  wire logic            hit,
    input  wire t_page_idx       hit_pa,
    input  wire logic            inject_q,
    input  wire t_vtp_lookup_rsp inject_rsp,
    input  wire t_req_meta       rd_meta,
    input  wire t_line_addr      rd_page_va,

    output logic                 out_valid,
    output t_vtp_req             out,
    output logic                 free_en,
    output t_req_tag             free_tag,
    output logic                 fill_en,
    output t_page_idx            fill_va,
    output t_page_idx            fill_pa
);

    // Main path when no translation is needed or the TLB had it
    logic      pick_main;
    logic      from_reply_q;
    t_page_idx pa_q;

    assign pick_main = st3.valid && (!st3.is_virtual || hit);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid    <= 1'b0;
            from_reply_q <= 1'b0;
            fill_en      <= 1'b0;
        end
        else
        begin
            out_valid    <= pick_main || inject_q;
            from_reply_q <= !pick_main && inject_q;
            // New translation goes into the TLB one cycle after its output
            fill_en      <= out_valid && from_reply_q;
        end

        if (pick_main)
        begin
            pa_q     <= st3.is_virtual ? hit_pa : st3.page;
            free_tag <= st3.tag;
        end
        else
        begin
            pa_q     <= inject_rsp.page_pa;
            free_tag <= inject_rsp.tag;
        end

        fill_va <= rd_page_va[LINE_ADDR_BITS-1:PAGE_OFFSET_BITS];
        fill_pa <= pa_q;
    end

    // Offset and metadata come back from the heap with the output
    always_comb
    begin
        out.meta       = rd_meta;
        out.line_addr  = {pa_q, rd_page_va[PAGE_OFFSET_BITS-1:0]};
        out.is_virtual = 1'b0;
    end

    assign free_en = out_valid;

endmodule

`default_nettype wire

// File: rtl/vtp_chan_top.sv
// ======================================================================
// Top level of one VTP request channel
// Intake, request heap, L1 TLB, miss path and emitter
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module vtp_chan_top
    import vtp_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset,

    // Request side
    input  wire logic            req_valid,
    input  wire t_vtp_req        req,
    output logic                 req_ready,
    input  wire logic            inval,

    // Translated output
    output logic                 out_valid,
    output t_vtp_req             out,
    input  wire logic            out_almost_full,

    // Translation service
    output logic                 svc_lookup_en,
    output t_vtp_lookup_req      svc_lookup,
    input  wire logic            svc_ready,
    input  wire logic            svc_rsp_valid,
    input  wire t_vtp_lookup_rsp svc_rsp
);

    t_vtp_stage      st0;
    t_vtp_stage      st1;
    t_vtp_stage      st2;
    t_vtp_stage      st3;

    t_req_tag        alloc_tag;
    logic            heap_not_full;
    logic            tlb_ready;
    logic            rsp_pending;

    logic            hit;
    t_page_idx       hit_pa;
    logic            inject_q;
    t_vtp_lookup_rsp inject_rsp;
    t_req_tag        heap_rd_tag;
    t_req_meta       rd_meta;
    t_line_addr      rd_page_va;

    logic            free_en;
    t_req_tag        free_tag;
    logic            fill_en;
    t_page_idx       fill_va;
    t_page_idx       fill_pa;

    vtp_req_intake intake (
        .clk, .reset, .req_valid, .req, .req_ready, .out_almost_full, .svc_ready,
        .tlb_ready, .heap_not_full, .rsp_pending, .alloc_tag,
        .st0, .st1, .st2, .st3
    );

    // Allocation and write command both come from stage 0
    vtp_req_heap heap (
        .clk, .reset, .alloc_en(st0.valid), .alloc_tag, .not_full(heap_not_full),
        .wr_en(st0.valid), .wr_tag(st0.tag), .wr_meta(req.meta), .wr_page_va(req.line_addr),
        .rd_tag(heap_rd_tag), .rd_meta, .rd_page_va, .free_en, .free_tag
    );

    vtp_l1_tlb tlb (
        .clk, .reset, .inval, .ready(tlb_ready), .st0, .st2, .hit, .hit_pa,
        .fill_en, .fill_va, .fill_pa
    );

    vtp_miss_path miss (
        .clk, .reset, .st2, .st3, .hit, .svc_lookup_en, .svc_lookup, .svc_rsp_valid,
        .svc_rsp, .rsp_pending, .inject_q, .inject_rsp, .heap_rd_tag
    );

    vtp_phys_emit emit (
        .clk, .reset, .st3, .hit, .hit_pa, .inject_q, .inject_rsp, .rd_meta, .rd_page_va,
        .out_valid, .out, .free_en, .free_tag, .fill_en, .fill_va, .fill_pa
    );

endmodule

`default_nettype wire

// File: sim/vtp_svc_model.sv
// ======================================================================
// Translation service model for the VTP channel testbench
// Answers each lookup once after a random delay of 1 to 8 cycles
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module vtp_svc_model
    import vtp_pkg::*;
#(
    parameter int        SEED    = 1,
    parameter t_page_idx PA_MASK = '0
)
(
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            lookup_en,
    input  wire t_vtp_lookup_req lookup,
    output logic                 ready,
    output logic                 rsp_valid,
    output t_vtp_lookup_rsp      rsp
);

    // Outstanding lookups and the cycle each one is due
    t_vtp_lookup_req pend_req [$];
    int unsigned     pend_due [$];
    int unsigned     now;
    int              seed = SEED;
    int              rnd;
    int              delay;
    int              pick;

    // Driven values, defined from time zero
    logic            ready_r = 1'b0;
    logic            rsp_valid_r = 1'b0;
    t_vtp_lookup_rsp rsp_r = '0;

    assign ready     = ready_r;
    assign rsp_valid = rsp_valid_r;
    assign rsp       = rsp_r;

    // Sampled and driven on the falling edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            pend_req.delete();
            pend_due.delete();
            now         = 0;
            ready_r     = 1'b0;
            rsp_valid_r = 1'b0;
        end
        else
        begin
            now     = now + 1;
            ready_r = 1'b1;
            if (lookup_en)
            begin
                rnd   = $random(seed);
                delay = 1 + (rnd & 7);
                pend_req.push_back(lookup);
                pend_due.push_back(now + delay);
            end
            // Oldest entry that is due goes first, one reply per cycle
            pick = -1;
            for (int i = 0; i < pend_due.size(); i++)
            begin
                if (pick < 0 && pend_due[i] <= now)
                    pick = i;
            end
            rsp_valid_r = (pick >= 0);
            if (pick >= 0)
            begin
                rsp_r.page_pa = pend_req[pick].page_va ^ PA_MASK;
                rsp_r.tag     = pend_req[pick].tag;
                pend_req.delete(pick);
                pend_due.delete(pick);
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_vtp_chan.sv
// ======================================================================
// Testbench for the VTP request channel
// Directed tests for reset, physical, miss and hit, invalidate, stream
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_vtp_chan
    import vtp_pkg::*;
();

    localparam t_page_idx TB_PA_MASK = 20'h5a5a5;
    localparam int        TB_SEED    = 32'hf9bf;

    localparam int        N_STREAM         = 200;
    localparam t_req_meta STREAM_META_BASE = 16'h8000;
    localparam int        STREAM_LIMIT     = 3000;
    // Reset and sweep near 90 cycles, directed tests under 200, stream capped above
    localparam int        TIMEOUT_CYCLES   = 4000;

    logic            clk = 1'b0;
    logic            reset;
    logic            req_valid;
    t_vtp_req        req;
    logic            req_ready;
    logic            inval;
    logic            out_valid;
    t_vtp_req        out;
    logic            out_almost_full;
    logic            svc_lookup_en;
    t_vtp_lookup_req svc_lookup;
    logic            svc_ready;
    logic            svc_rsp_valid;
    t_vtp_lookup_rsp svc_rsp;

    int              seed;
    int              errors = 0;
    int              checks = 0;
    int              tests = 0;
    int              errors_at_start = 0;
    int unsigned     cycle_count = 0;

    // Stream stimulus and scoreboard, indexed by metadata
    t_vtp_req        stream_req [N_STREAM];
    t_vtp_req        exp_out    [N_STREAM];
    bit              seen       [N_STREAM];

    always #4 clk = ~clk;

    vtp_chan_top uut (
        .clk, .reset, .req_valid, .req, .req_ready, .inval, .out_valid, .out,
        .out_almost_full, .svc_lookup_en, .svc_lookup, .svc_ready, .svc_rsp_valid, .svc_rsp
    );

    vtp_svc_model #(.SEED(TB_SEED), .PA_MASK(TB_PA_MASK)) svc (
        .clk, .reset, .lookup_en(svc_lookup_en), .lookup(svc_lookup), .ready(svc_ready),
        .rsp_valid(svc_rsp_valid), .rsp(svc_rsp)
    );

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run stopped making progress", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    // ==================================================================
    // Reference rules and checks
    // ==================================================================

    // Physical passes unchanged, virtual gets page XOR mask and keeps offset
    function automatic t_vtp_req expected_out(input t_vtp_req r);
        t_vtp_req e;
        e = r;
        if (r.is_virtual)
            e.line_addr = {r.line_addr[25:6] ^ TB_PA_MASK, r.line_addr[5:0]};
        e.is_virtual = 1'b0;
        return e;
    endfunction

    // Eight stream pages, the last one shares a TLB slot with the first
    function automatic t_page_idx stream_page(input logic [2:0] k);
        case (k)
            3'd0:    return 20'h00401;
            3'd1:    return 20'h12342;
            3'd2:    return 20'h3ff83;
            3'd3:    return 20'h0a004;
            3'd4:    return 20'h55545;
            3'd5:    return 20'haaa86;
            3'd6:    return 20'h7f007;
            default: return 20'hc3c01;
        endcase
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_req(input string name, input t_vtp_req got, input t_vtp_req exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_lookup(input string name, input t_vtp_lookup_req got,
                                input t_vtp_lookup_req exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic start_test();
        tests++;
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start)
            $display("Test %s: passed", name);
        else
            $display("Test %s: FAILED with %0d errors", name, errors - errors_at_start);
    endtask

    // ==================================================================
    // Stimulus helpers, all entered and left on a falling edge
    // ==================================================================

    task automatic wait_ready(input int limit, output bit ok);
        int n;
        n = 0;
        while (!req_ready && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        ok = req_ready;
    endtask

    // Accepted on the rising edge between the two falling edges
    task automatic send_req(input t_vtp_req r);
        bit ok;
        wait_ready(100, ok);
        if (!ok)
            report_error("req_ready stayed low for 100 cycles, request could not be sent");
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Follows one request from its first falling edge after acceptance
    task automatic track_request(input t_vtp_req r, input bit expect_miss);
        int              n;
        int              lookups;
        int              lookup_at;
        int              out_at;
        t_vtp_lookup_req exp_lk;
        n         = 1;
        lookups   = 0;
        lookup_at = 0;
        out_at    = 0;
        // Heap is empty here, so the lowest tag is handed out
        exp_lk.page_va = r.line_addr[25:6];
        exp_lk.tag     = '0;
        while (out_at == 0 && n <= 60)
        begin
            if (svc_lookup_en)
            begin
                lookups++;
                lookup_at = n;
                check_lookup("svc_lookup", svc_lookup, exp_lk);
            end
            if (out_valid)
            begin
                out_at = n;
                check_req("out", out, expected_out(r));
            end
            else
            begin
                @(negedge clk);
                n++;
            end
        end
        if (out_at == 0)
            report_error("no output within 60 cycles of acceptance");
        check_bit("svc_lookup_en seen", lookups != 0, expect_miss);
        if (expect_miss)
            check_bit("svc_lookup_en at edge 4", lookup_at == 4, 1'b1);
        else
            check_bit("out_valid at edge 4", out_at == 4, 1'b1);
        @(negedge clk);
    endtask

    // ==================================================================
    // Directed tests
    // ==================================================================

    task automatic test_reset();
        int   n;
        logic stray;
        start_test();
        stray = 1'b0;
        check_bit("req_ready after reset", req_ready, 1'b0);
        n = 0;
        // Sweep of 64 entries plus the registered ready
        while (!req_ready && n < 70)
        begin
            if (out_valid !== 1'b0 || svc_lookup_en !== 1'b0)
                stray = 1'b1;
            @(negedge clk);
            n++;
        end
        check_bit("out_valid or svc_lookup_en during sweep", stray, 1'b0);
        check_bit("req_ready within 70 cycles", req_ready, 1'b1);
        finish_test("reset and sweep");
    endtask

    task automatic test_physical();
        t_vtp_req r;
        start_test();
        r.meta       = 16'h0101;
        r.line_addr  = 26'h2abcdef;
        r.is_virtual = 1'b0;
        send_req(r);
        track_request(r, 1'b0);
        finish_test("physical request");
    endtask

    task automatic test_miss_then_hit();
        t_vtp_req r;
        start_test();
        r.meta       = 16'h0202;
        r.line_addr  = {20'h1c3a5, 6'h2a};
        r.is_virtual = 1'b1;
        send_req(r);
        track_request(r, 1'b1);
        // Let the fill reach the TLB
        repeat (4) @(negedge clk);
        r.meta      = 16'h0203;
        r.line_addr = {20'h1c3a5, 6'h15};
        send_req(r);
        track_request(r, 1'b0);
        finish_test("miss then hit");
    endtask

    task automatic test_invalidate();
        t_vtp_req r;
        int       n;
        bit       ok;
        start_test();
        inval = 1'b1;
        @(negedge clk);
        inval = 1'b0;
        n = 0;
        while (req_ready && n < 10)
        begin
            @(negedge clk);
            n++;
        end
        check_bit("req_ready falls after inval", req_ready, 1'b0);
        wait_ready(80, ok);
        check_bit("req_ready back after sweep", ok, 1'b1);
        r.meta       = 16'h0304;
        r.line_addr  = {20'h1c3a5, 6'h07};
        r.is_virtual = 1'b1;
        send_req(r);
        track_request(r, 1'b1);
        finish_test("invalidate");
    endtask

    task automatic test_stream();
        logic [31:0] rnd;
        int          sent;
        int          received;
        int          cycles;
        int          idx;
        bit          ready_at_drive;
        bit          af_before;
        start_test();
        for (int i = 0; i < N_STREAM; i++)
        begin
            rnd = $random(seed);
            stream_req[i].meta       = STREAM_META_BASE + t_req_meta'(i);
            stream_req[i].line_addr  = {stream_page(rnd[2:0]), rnd[8:3]};
            stream_req[i].is_virtual = (rnd[11:9] != 3'd0);
            exp_out[i] = expected_out(stream_req[i]);
            seen[i]    = 1'b0;
        end
        sent           = 0;
        received       = 0;
        cycles         = 0;
        ready_at_drive = 1'b0;
        while ((sent < N_STREAM || received < N_STREAM) && cycles < STREAM_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            // Scoreboard side
            if (out_valid)
            begin
                idx = int'(out.meta) - int'(STREAM_META_BASE);
                if (idx < 0 || idx >= N_STREAM)
                    report_error($sformatf("output with unknown meta %h", out.meta));
                else if (seen[idx])
                    report_error($sformatf("request %0d came out twice", idx));
                else
                begin
                    seen[idx] = 1'b1;
                    received++;
                    check_req($sformatf("out[%0d]", idx), out, exp_out[idx]);
                end
            end
            // Request driven last falling edge went in on the rising edge
            if (req_valid && ready_at_drive)
                sent++;
            af_before = out_almost_full;
            rnd = $random(seed);
            if (rnd[3:0] == 4'h0)
                out_almost_full = !out_almost_full;
            if (sent < N_STREAM)
            begin
                req_valid      = 1'b1;
                req            = stream_req[sent];
                ready_at_drive = req_ready;
                // Almost-full high since the last falling edge must block intake
                if (req_ready && af_before)
                    report_error("request accepted more than one cycle after almost-full");
            end
            else
            begin
                req_valid      = 1'b0;
                ready_at_drive = 1'b0;
            end
        end
        req_valid       = 1'b0;
        out_almost_full = 1'b0;
        if (received < N_STREAM)
            report_error($sformatf("only %0d of %0d stream requests came out",
                                   received, N_STREAM));
        // Nothing more may leave after the last one
        repeat (20)
        begin
            @(negedge clk);
            if (out_valid)
                report_error("extra output after the stream completed");
        end
        finish_test("stream with back-pressure");
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial
    begin
        seed            = TB_SEED;
        reset           = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        inval           = 1'b0;
        out_almost_full = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset();
        test_physical();
        test_miss_then_hit();
        test_invalidate();
        test_stream();

        $display("Summary: %0d tests, %0d checks, %0d failed", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/vtp_pkg.sv
rtl/vtp_req_intake.sv
rtl/vtp_req_heap.sv
rtl/vtp_l1_tlb.sv
rtl/vtp_miss_path.sv
rtl/vtp_phys_emit.sv
rtl/vtp_chan_top.sv
sim/vtp_svc_model.sv
sim/tb_vtp_chan.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the VTP channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_vtp_chan -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_vtp_chan)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
